// File: Bender.yml
package:
  name: periph_top

sources:
  - soc_pkg.sv
  - axi_lite_pkg.sv
  - reset_sync.sv
  - axil_periph_bridge.sv
  - periph_bus.sv
  - clint.sv
  - cycle_timer.sv
  - button_port.sv
  - periph_top.sv
  - target: test
    files:
      - tb_periph_top.sv

// File: axi_lite_pkg.sv
package axi_lite_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    localparam int AXI_ADDR_WIDTH = 16;
    localparam int AXI_DATA_WIDTH = 32;
    // one strobe per data byte
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

endpackage

// File: axil_periph_bridge.sv
`timescale 1ns/1ns

module axil_periph_bridge (
    input  logic clk,
    input  logic rst_n,

    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                    wvalid,
    output logic                                    wready,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic [axi_lite_pkg::AXI_STRB_WIDTH-1:0] wstrb,
    output logic                                    bvalid,
    input  logic                                    bready,
    output axi_lite_pkg::resp_e                     bresp,
    input  logic                                    arvalid,
    output logic                                    arready,
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    output logic                                    rvalid,
    input  logic                                    rready,
    output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output axi_lite_pkg::resp_e                     rresp,

    output logic                req_valid,
    output logic                req_write,
    output soc_pkg::addr_t      req_addr,
    output soc_pkg::data_t      req_wdata,
    output soc_pkg::strb_t      req_wstrb,
    input  soc_pkg::data_t      rsp_rdata,
    input  axi_lite_pkg::resp_e rsp_resp
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } state_e;

    state_e              state;
    state_e              state_next;
    logic                read_accept;
    logic                write_accept;
    soc_pkg::data_t      rdata_q;
    axi_lite_pkg::resp_e resp_q;

    // reads win over a waiting write
    assign read_accept  = (state == IDLE) && arvalid;
    assign write_accept = (state == IDLE) && !arvalid && awvalid && wvalid;

    assign arready = read_accept;
    assign awready = write_accept;
    assign wready  = write_accept;

    // one request in the acceptance cycle
    assign req_valid = read_accept || write_accept;
    assign req_write = write_accept;
    assign req_addr  = read_accept ? araddr : awaddr;
    assign req_wdata = wdata;
    assign req_wstrb = wstrb;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (read_accept) begin
                    state_next = READ_RESP;
                end else if (write_accept) begin
                    state_next = WRITE_RESP;
                end
            end
            WRITE_RESP: begin
                if (bready) begin
                    state_next = IDLE;
                end
            end
            READ_RESP: begin
                if (rready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // bus answers in the request cycle, hold it until the master takes it
    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp_q <= rsp_resp;
            if (!req_write) begin
                rdata_q <= rsp_rdata;
            end
        end
    end

    assign bvalid = (state == WRITE_RESP);
    assign rvalid = (state == READ_RESP);
    assign bresp  = resp_q;
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

endmodule

// File: button_port.sv
`timescale 1ns/1ns

module button_port (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [soc_pkg::BUTTON_COUNT-1:0] buttons_n,
    output logic [soc_pkg::BUTTON_COUNT-1:0] pressed
);

    logic [soc_pkg::BUTTON_COUNT-1:0] sync_1;
    logic [soc_pkg::BUTTON_COUNT-1:0] sync_2;

    // pins are active low, invert at the first stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= ~buttons_n;
            sync_2 <= sync_1;
        end
    end

    assign pressed = sync_2;

endmodule

// File: clint.sv
`timescale 1ns/1ns

module clint (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             we,
    input  soc_pkg::offset_t offset,
    input  soc_pkg::data_t   wdata,
    input  soc_pkg::strb_t   wstrb,
    output soc_pkg::data_t   rdata,
    output logic             offset_valid,
    output logic             msw_irq,
    output logic             mtimer_irq
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [63:0] mtime_next;
    logic        msip;

    // replace only the strobed bytes
    function automatic soc_pkg::data_t merge_bytes(
        input soc_pkg::data_t old_word,
        input soc_pkg::data_t new_word,
        input soc_pkg::strb_t strb
    );
        soc_pkg::data_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    // a write to one half overrides that half of the increment
    always_comb begin
        mtime_next = mtime + 64'd1;
        if (we && offset == soc_pkg::CLINT_MTIME_LO) begin
            mtime_next[31:0] = merge_bytes(mtime_next[31:0], wdata, wstrb);
        end
        if (we && offset == soc_pkg::CLINT_MTIME_HI) begin
            mtime_next[63:32] = merge_bytes(mtime_next[63:32], wdata, wstrb);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime      <= '0;
            mtimecmp   <= '1;
            msip       <= 1'b0;
            mtimer_irq <= 1'b0;
        end else begin
            mtime      <= mtime_next;
            mtimer_irq <= (mtime >= mtimecmp);
            if (we) begin
                case (offset)
                    soc_pkg::CLINT_MSIP: begin
                        if (wstrb[0]) begin
                            msip <= wdata[0];
                        end
                    end
                    soc_pkg::CLINT_MTIMECMP_LO: begin
                        mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], wdata, wstrb);
                    end
                    soc_pkg::CLINT_MTIMECMP_HI: begin
                        mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], wdata, wstrb);
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        offset_valid = 1'b1;
        case (offset)
            soc_pkg::CLINT_MSIP:        rdata = {31'b0, msip};
            soc_pkg::CLINT_MTIMECMP_LO: rdata = mtimecmp[31:0];
            soc_pkg::CLINT_MTIMECMP_HI: rdata = mtimecmp[63:32];
            soc_pkg::CLINT_MTIME_LO:    rdata = mtime[31:0];
            soc_pkg::CLINT_MTIME_HI:    rdata = mtime[63:32];
            default: begin
                rdata        = '0;
                offset_valid = 1'b0;
            end
        endcase
    end

    assign msw_irq = msip;

endmodule

// File: cycle_timer.sv
`timescale 1ns/1ns

module cycle_timer #(
    parameter int DIVISION = 1
) (
    input  logic           clk,
    input  logic           rst_n,
    output soc_pkg::data_t count
);

    localparam int PRE_WIDTH = $clog2(DIVISION + 1);
    localparam logic [PRE_WIDTH-1:0] PRE_LAST = PRE_WIDTH'(DIVISION - 1);

    logic [PRE_WIDTH-1:0] prescale;
    logic                 tick;

    // tick once per DIVISION cycles
    assign tick = (prescale == PRE_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale <= '0;
            count    <= '0;
        end else begin
            if (tick) begin
                prescale <= '0;
                count    <= count + 32'd1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

// File: filelist.f
soc_pkg.sv
axi_lite_pkg.sv
reset_sync.sv
axil_periph_bridge.sv
periph_bus.sv
clint.sv
cycle_timer.sv
button_port.sv
periph_top.sv
tb_periph_top.sv

// File: periph_bus.sv
`timescale 1ns/1ns

module periph_bus (
    input  logic                              req_valid,
    input  logic                              req_write,
    input  soc_pkg::addr_t                    req_addr,
    input  soc_pkg::data_t                    req_wdata,
    input  soc_pkg::strb_t                    req_wstrb,
    output soc_pkg::data_t                    rsp_rdata,
    output axi_lite_pkg::resp_e               rsp_resp,
    output soc_pkg::offset_t                  offset,
    output soc_pkg::data_t                    wdata,
    output soc_pkg::strb_t                    wstrb,
    output logic                              clint_we,
    input  soc_pkg::data_t                    clint_rdata,
    input  logic                              clint_offset_valid,
    input  soc_pkg::data_t                    timer_fast,
    input  soc_pkg::data_t                    timer_slow,
    input  logic [soc_pkg::BUTTON_COUNT-1:0] buttons_pressed
);

    soc_pkg::region_e region;

    always_comb begin
        if (req_addr[15:12] == soc_pkg::BUTTONS_BASE[15:12]) begin
            region = soc_pkg::REGION_BUTTONS;
        end else if (req_addr[15:12] == soc_pkg::TIMER_BASE[15:12]) begin
            region = soc_pkg::REGION_TIMER;
        end else if (req_addr[15:12] == soc_pkg::CLINT_BASE[15:12]) begin
            region = soc_pkg::REGION_CLINT;
        end else begin
            region = soc_pkg::REGION_NONE;
        end
    end

    assign offset = req_addr[7:0];
    assign wdata  = req_wdata;
    assign wstrb  = req_wstrb;

    // clint is the only writable region
    assign clint_we = req_valid && req_write && (region == soc_pkg::REGION_CLINT);

    always_comb begin
        rsp_rdata = '0;
        rsp_resp  = axi_lite_pkg::RESP_OKAY;
        case (region)
            soc_pkg::REGION_BUTTONS: begin
                if (req_write || offset != soc_pkg::BUTTONS_PRESSED) begin
                    rsp_resp = axi_lite_pkg::RESP_SLVERR;
                end else begin
                    rsp_rdata = soc_pkg::data_t'(buttons_pressed);
                end
            end
            soc_pkg::REGION_TIMER: begin
                if (req_write) begin
                    rsp_resp = axi_lite_pkg::RESP_SLVERR;
                end else if (offset == soc_pkg::TIMER_FAST) begin
                    rsp_rdata = timer_fast;
                end else if (offset == soc_pkg::TIMER_SLOW) begin
                    rsp_rdata = timer_slow;
                end else begin
                    rsp_resp = axi_lite_pkg::RESP_SLVERR;
                end
            end
            soc_pkg::REGION_CLINT: begin
                // offset check lives in the clint itself
                if (!clint_offset_valid) begin
                    rsp_resp = axi_lite_pkg::RESP_SLVERR;
                end else if (!req_write) begin
                    rsp_rdata = clint_rdata;
                end
            end
            default: rsp_resp = axi_lite_pkg::RESP_DECERR;
        endcase
    end

endmodule

// File: periph_top.sv
`timescale 1ns/1ns

module periph_top (
    input  logic clk,
    input  logic ext_reset,

    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                    wvalid,
    output logic                                    wready,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic [axi_lite_pkg::AXI_STRB_WIDTH-1:0] wstrb,
    output logic                                    bvalid,
    input  logic                                    bready,
    output axi_lite_pkg::resp_e                     bresp,
    input  logic                                    arvalid,
    output logic                                    arready,
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    output logic                                    rvalid,
    input  logic                                    rready,
    output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output axi_lite_pkg::resp_e                     rresp,

    input  logic [soc_pkg::BUTTON_COUNT-1:0] buttons_n,
    output logic                             msw_irq,
    output logic                             mtimer_irq
);

    logic                             rst_n;
    logic                             req_valid;
    logic                             req_write;
    soc_pkg::addr_t                   req_addr;
    soc_pkg::data_t                   req_wdata;
    soc_pkg::strb_t                   req_wstrb;
    soc_pkg::data_t                   rsp_rdata;
    axi_lite_pkg::resp_e              rsp_resp;
    soc_pkg::offset_t                 bus_offset;
    soc_pkg::data_t                   bus_wdata;
    soc_pkg::strb_t                   bus_wstrb;
    logic                             clint_we;
    soc_pkg::data_t                   clint_rdata;
    logic                             clint_offset_valid;
    soc_pkg::data_t                   timer_fast;
    soc_pkg::data_t                   timer_slow;
    logic [soc_pkg::BUTTON_COUNT-1:0] buttons_pressed;

    reset_sync reset_sync_i (
        .clk       (clk),
        .ext_reset (ext_reset),
        .rst_n     (rst_n)
    );

    axil_periph_bridge bridge_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .rsp_rdata (rsp_rdata),
        .rsp_resp  (rsp_resp)
    );

    periph_bus bus_i (
        .req_valid          (req_valid),
        .req_write          (req_write),
        .req_addr           (req_addr),
        .req_wdata          (req_wdata),
        .req_wstrb          (req_wstrb),
        .rsp_rdata          (rsp_rdata),
        .rsp_resp           (rsp_resp),
        .offset             (bus_offset),
        .wdata              (bus_wdata),
        .wstrb              (bus_wstrb),
        .clint_we           (clint_we),
        .clint_rdata        (clint_rdata),
        .clint_offset_valid (clint_offset_valid),
        .timer_fast         (timer_fast),
        .timer_slow         (timer_slow),
        .buttons_pressed    (buttons_pressed)
    );

    clint clint_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .we           (clint_we),
        .offset       (bus_offset),
        .wdata        (bus_wdata),
        .wstrb        (bus_wstrb),
        .rdata        (clint_rdata),
        .offset_valid (clint_offset_valid),
        .msw_irq      (msw_irq),
        .mtimer_irq   (mtimer_irq)
    );

    cycle_timer #(.DIVISION(1)) timer_fast_i (
        .clk   (clk),
        .rst_n (rst_n),
        .count (timer_fast)
    );

    cycle_timer #(.DIVISION(soc_pkg::SLOW_DIVISION)) timer_slow_i (
        .clk   (clk),
        .rst_n (rst_n),
        .count (timer_slow)
    );

    button_port button_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .buttons_n (buttons_n),
        .pressed   (buttons_pressed)
    );

endmodule

// File: reset_sync.sv
`timescale 1ns/1ns

module reset_sync (
    input  logic clk,
    input  logic ext_reset,
    output logic rst_n
);

    // fills with ones from the bottom, full after four edges
    logic [3:0] fill;

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            fill <= '0;
        end else begin
            fill <= {fill[2:0], 1'b1};
        end
    end

    // top stage is only set once all lower stages are
    assign rst_n = fill[3];

endmodule

// File: soc_pkg.sv
package soc_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  offset_t;

    typedef enum logic [1:0] {
        REGION_BUTTONS,
        REGION_TIMER,
        REGION_CLINT,
        REGION_NONE
    } region_e;

    // region bases, decoded on address bits 15 to 12
    localparam addr_t BUTTONS_BASE = 16'h1000;
    localparam addr_t TIMER_BASE   = 16'h2000;
    localparam addr_t CLINT_BASE   = 16'h3000;

    // clint register offsets
    localparam offset_t CLINT_MSIP        = 8'h00;
    localparam offset_t CLINT_MTIMECMP_LO = 8'h04;
    localparam offset_t CLINT_MTIMECMP_HI = 8'h08;
    localparam offset_t CLINT_MTIME_LO    = 8'h0C;
    localparam offset_t CLINT_MTIME_HI    = 8'h10;

    // counter offsets in the timer region
    localparam offset_t TIMER_FAST = 8'h00;
    localparam offset_t TIMER_SLOW = 8'h04;

    // single register in the button region
    localparam offset_t BUTTONS_PRESSED = 8'h00;

    localparam int SLOW_DIVISION = 50;
    localparam int BUTTON_COUNT  = 8;

endpackage

// File: tb_periph_top.sv
`timescale 1ns/1ns

module tb_periph_top;

    localparam int CLK_PERIOD      = 20;
    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 2000;

    logic                                    clk;
    logic                                    ext_reset;
    logic                                    awvalid;
    logic                                    awready;
    logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] awaddr;
    logic                                    wvalid;
    logic                                    wready;
    logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] wdata;
    logic [axi_lite_pkg::AXI_STRB_WIDTH-1:0] wstrb;
    logic                                    bvalid;
    logic                                    bready;
    axi_lite_pkg::resp_e                     bresp;
    logic                                    arvalid;
    logic                                    arready;
    logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] araddr;
    logic                                    rvalid;
    logic                                    rready;
    logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] rdata;
    axi_lite_pkg::resp_e                     rresp;
    logic [soc_pkg::BUTTON_COUNT-1:0]        buttons_n;
    logic                                    msw_irq;
    logic                                    mtimer_irq;

    int    error_count = 0;
    string test_name   = "none";

    periph_top periph_top_i (
        .clk        (clk),
        .ext_reset  (ext_reset),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .buttons_n  (buttons_n),
        .msw_irq    (msw_irq),
        .mtimer_irq (mtimer_irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // run limit scaled to the number of tests
    initial begin
        repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired, tests did not complete within %0d cycles",
                 TEST_COUNT * CYCLES_PER_TEST);
        $display("Finished with errors");
        $finish;
    end

    function automatic soc_pkg::addr_t clint_addr(input soc_pkg::offset_t offset);
        return soc_pkg::CLINT_BASE + soc_pkg::addr_t'(offset);
    endfunction

    task automatic check_data(input string what, input soc_pkg::data_t expected,
                              input soc_pkg::data_t actual);
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_resp(input string what, input axi_lite_pkg::resp_e expected,
                              input axi_lite_pkg::resp_e actual);
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s %s expected %s actual %s", test_name, what,
                     expected.name(), actual.name());
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic axil_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                              input soc_pkg::strb_t strb, output axi_lite_pkg::resp_e resp);
        @(posedge clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        bready  <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input soc_pkg::addr_t addr, output soc_pkg::data_t data,
                             output axi_lite_pkg::resp_e resp);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic reset_state_test();
        soc_pkg::data_t      data;
        axi_lite_pkg::resp_e resp;
        test_name = "reset_state";
        @(negedge clk);
        check_bit("msw_irq", 1'b0, msw_irq);
        check_bit("mtimer_irq", 1'b0, mtimer_irq);
        check_bit("awready", 1'b0, awready);
        check_bit("wready", 1'b0, wready);
        check_bit("arready", 1'b0, arready);
        check_bit("bvalid", 1'b0, bvalid);
        check_bit("rvalid", 1'b0, rvalid);
        axil_read(clint_addr(soc_pkg::CLINT_MTIMECMP_LO), data, resp);
        check_data("mtimecmp lo", 32'hFFFF_FFFF, data);
        check_resp("mtimecmp lo resp", axi_lite_pkg::RESP_OKAY, resp);
        axil_read(clint_addr(soc_pkg::CLINT_MTIMECMP_HI), data, resp);
        check_data("mtimecmp hi", 32'hFFFF_FFFF, data);
        check_resp("mtimecmp hi resp", axi_lite_pkg::RESP_OKAY, resp);
    endtask

    task automatic button_test();
        logic [soc_pkg::BUTTON_COUNT-1:0] pattern;
        soc_pkg::data_t                   expected;
        soc_pkg::data_t                   data;
        axi_lite_pkg::resp_e              resp;
        test_name = "buttons";
        for (int i = 0; i < 8; i++) begin
            pattern = soc_pkg::BUTTON_COUNT'($urandom);
            @(posedge clk);
            buttons_n <= pattern;
            // let the synchronizer settle
            repeat (3) @(posedge clk);
            expected = {{(32 - soc_pkg::BUTTON_COUNT){1'b0}}, ~pattern};
            axil_read(soc_pkg::BUTTONS_BASE, data, resp);
            check_data("pressed", expected, data);
            check_resp("pressed resp", axi_lite_pkg::RESP_OKAY, resp);
        end
    endtask

    task automatic msip_test();
        axi_lite_pkg::resp_e resp;
        test_name = "msip";
        axil_write(clint_addr(soc_pkg::CLINT_MSIP), 32'h1, 4'b0001, resp);
        check_resp("set resp", axi_lite_pkg::RESP_OKAY, resp);
        @(negedge clk);
        check_bit("msw_irq after set", 1'b1, msw_irq);
        axil_write(clint_addr(soc_pkg::CLINT_MSIP), 32'h0, 4'b0001, resp);
        @(negedge clk);
        check_bit("msw_irq after clear", 1'b0, msw_irq);
        // byte 0 not strobed, so bit 0 keeps its value
        axil_write(clint_addr(soc_pkg::CLINT_MSIP), 32'hFFFF_FFFF, 4'b1110, resp);
        @(negedge clk);
        check_bit("msw_irq unstrobed", 1'b0, msw_irq);
    endtask

    task automatic timer_irq_test();
        soc_pkg::data_t      mtime_lo;
        axi_lite_pkg::resp_e resp;
        int                  waited;
        test_name = "timer_irq";
        axil_read(clint_addr(soc_pkg::CLINT_MTIME_LO), mtime_lo, resp);
        axil_write(clint_addr(soc_pkg::CLINT_MTIMECMP_HI), 32'h0, 4'hF, resp);
        axil_write(clint_addr(soc_pkg::CLINT_MTIMECMP_LO), mtime_lo + 32'd200, 4'hF, resp);
        check_resp("mtimecmp resp", axi_lite_pkg::RESP_OKAY, resp);
        @(negedge clk);
        check_bit("mtimer_irq early", 1'b0, mtimer_irq);
        waited = 0;
        while (!mtimer_irq && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (!mtimer_irq) begin
            error_count++;
            $display("%s: mtimer_irq did not rise within 400 cycles", test_name);
        end
        axil_write(clint_addr(soc_pkg::CLINT_MTIMECMP_LO), 32'hFFFF_FFFF, 4'hF, resp);
        @(negedge clk);
        check_bit("mtimer_irq cleared", 1'b0, mtimer_irq);
    endtask

    task automatic counter_rate_test();
        soc_pkg::data_t      fast_a;
        soc_pkg::data_t      slow_a;
        soc_pkg::data_t      fast_b;
        soc_pkg::data_t      slow_b;
        soc_pkg::data_t      fast_diff;
        soc_pkg::data_t      slow_scaled;
        axi_lite_pkg::resp_e resp;
        test_name = "counter_rate";
        axil_read(soc_pkg::TIMER_BASE + soc_pkg::addr_t'(soc_pkg::TIMER_FAST), fast_a, resp);
        axil_read(soc_pkg::TIMER_BASE + soc_pkg::addr_t'(soc_pkg::TIMER_SLOW), slow_a, resp);
        repeat (700 + ($urandom % 300)) @(posedge clk);
        axil_read(soc_pkg::TIMER_BASE + soc_pkg::addr_t'(soc_pkg::TIMER_FAST), fast_b, resp);
        axil_read(soc_pkg::TIMER_BASE + soc_pkg::addr_t'(soc_pkg::TIMER_SLOW), slow_b, resp);
        check_resp("slow resp", axi_lite_pkg::RESP_OKAY, resp);
        fast_diff   = fast_b - fast_a;
        slow_scaled = (slow_b - slow_a) * soc_pkg::SLOW_DIVISION;
        // one slow tick of slack on either side
        if (fast_diff + soc_pkg::SLOW_DIVISION < slow_scaled ||
            fast_diff > slow_scaled + soc_pkg::SLOW_DIVISION) begin
            error_count++;
            $display("%s: fast counter moved %0d but slow counter moved %0d", test_name,
                     fast_diff, slow_b - slow_a);
        end
    endtask

    task automatic error_resp_test();
        soc_pkg::data_t      data;
        soc_pkg::data_t      held;
        axi_lite_pkg::resp_e resp;
        test_name = "error_resp";
        axil_read(16'h5000, data, resp);
        check_resp("unmapped read", axi_lite_pkg::RESP_DECERR, resp);
        axil_write(soc_pkg::BUTTONS_BASE, 32'h1, 4'hF, resp);
        check_resp("button write", axi_lite_pkg::RESP_SLVERR, resp);
        axil_write(soc_pkg::TIMER_BASE, 32'h1, 4'hF, resp);
        check_resp("timer write", axi_lite_pkg::RESP_SLVERR, resp);

        test_name = "back_pressure";
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= clint_addr(soc_pkg::CLINT_MTIME_LO);
        rready  <= 1'b0;
        do @(negedge clk); while (!arready);
        // queue a write behind the stalled read
        @(posedge clk);
        arvalid <= 1'b0;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= clint_addr(soc_pkg::CLINT_MSIP);
        wdata   <= 32'h1;
        wstrb   <= 4'b0001;
        bready  <= 1'b1;
        do @(negedge clk); while (!rvalid);
        held = rdata;
        repeat (20) begin
            @(negedge clk);
            check_bit("rvalid held", 1'b1, rvalid);
            check_data("rdata held", held, rdata);
            check_bit("awready while stalled", 1'b0, awready);
            check_bit("wready while stalled", 1'b0, wready);
            check_bit("msw_irq while stalled", 1'b0, msw_irq);
        end
        @(posedge clk);
        rready <= 1'b1;
        do @(negedge clk); while (!awready);
        @(posedge clk);
        rready  <= 1'b0;
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clk); while (!bvalid);
        check_resp("queued write resp", axi_lite_pkg::RESP_OKAY, bresp);
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        check_bit("msw_irq after queued write", 1'b1, msw_irq);
        axil_write(clint_addr(soc_pkg::CLINT_MSIP), 32'h0, 4'b0001, resp);
    endtask

    initial begin
        void'($urandom(32'h69c8_78f0));
        clk       = 1'b0;
        ext_reset <= 1'b0;
        awvalid   <= 1'b0;
        awaddr    <= '0;
        wvalid    <= 1'b0;
        wdata     <= '0;
        wstrb     <= '0;
        bready    <= 1'b0;
        arvalid   <= 1'b0;
        araddr    <= '0;
        rready    <= 1'b0;
        buttons_n <= '1;
        repeat (10) @(posedge clk);
        ext_reset <= 1'b1;
        // internal reset releases a few edges later
        repeat (6) @(posedge clk);

        reset_state_test();
        button_test();
        msip_test();
        timer_irq_test();
        counter_rate_test();
        error_resp_test();

        repeat (2) @(posedge clk);
        $display("checks complete with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
